//--- source/dmi_defs.svh
`ifndef DMI_DEFS_SVH
`define DMI_DEFS_SVH

// Length of the JTAG instruction register.
`define DMI_IR_LEN 5

// Value shifted out of the IDCODE register.
`define DMI_IDCODE 32'h1000_0DB3

// Width of a DMI address, also reported in dtmcs.abits.
`define DMI_ABITS 7

// Number of registers implemented by the debug target.
`define DMI_NREGS 16

// Cycles from a request strobe to its response strobe.
`define DMI_RESP_LAT 4

`endif

//--- source/dmi_pkg.sv
`include "dmi_defs.svh"

package dmi_pkg;

	typedef logic [`DMI_ABITS-1:0] dmi_addr_t;
	typedef logic [31:0] dmi_data_t;
	typedef logic [`DMI_IR_LEN-1:0] ir_t;

	// Requests use nop, read and write. Responses reuse the same field.
	typedef enum logic [1:0] {
		op_nop   = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2,
		op_busy  = 2'd3
	} dmi_op_e;

	localparam dmi_op_e op_success = op_nop;
	localparam dmi_op_e op_failed = op_write;

	typedef enum logic [3:0] {
		st_reset, st_idle, st_select_dr, st_capture_dr,
		st_shift_dr, st_exit1_dr, st_pause_dr, st_exit2_dr,
		st_update_dr, st_select_ir, st_capture_ir, st_shift_ir,
		st_exit1_ir, st_pause_ir, st_exit2_ir, st_update_ir
	} tap_state_e;

	typedef struct packed {
		dmi_addr_t addr;
		dmi_data_t data;
		dmi_op_e   op;
	} dmi_req_t;

	typedef struct packed {
		dmi_data_t data;
		dmi_op_e   op;
	} dmi_resp_t;

endpackage

//--- source/dmi_jtag_tap.sv
`timescale 1ns/10ps
`include "dmi_defs.svh"

module dmi_jtag_tap import dmi_pkg::*; (
	input  logic       tck_i,
	input  logic       trst_ni,
	input  logic       tms_i,
	input  logic       td_i,
	input  logic [1:0] dmi_error_i,
	input  logic       dmi_tdo_i,
	output logic       td_o,
	output logic       tdo_oe_o,
	output logic       capture_dr_o,
	output logic       shift_dr_o,
	output logic       update_dr_o,
	output logic       dmi_access_o,
	output logic       dtmcs_select_o,
	output logic       dmi_reset_o
);

	localparam ir_t ir_idcode = 'h01;
	localparam ir_t ir_dtmcs = 'h10;
	localparam ir_t ir_dmi = 'h11;
	localparam ir_t ir_capture = 'b00101;

	tap_state_e  tap_state_q;
	tap_state_e  tap_state_d;
	logic        test_logic_reset;
	logic        capture_ir;
	logic        shift_ir;
	logic        update_ir;
	ir_t         ir_shift_q;
	ir_t         ir_q;
	logic        bypass_q;
	logic [31:0] idcode_q;
	logic [31:0] dtmcs_q;
	logic        idcode_select;
	logic        bypass_select;
	logic        tdo_mux;

	always_comb begin
		tap_state_d = tap_state_q;
		unique case (tap_state_q)
			st_reset:      tap_state_d = tms_i ? st_reset     : st_idle;
			st_idle:       tap_state_d = tms_i ? st_select_dr : st_idle;
			st_select_dr:  tap_state_d = tms_i ? st_select_ir : st_capture_dr;
			st_capture_dr: tap_state_d = tms_i ? st_exit1_dr  : st_shift_dr;
			st_shift_dr:   tap_state_d = tms_i ? st_exit1_dr  : st_shift_dr;
			st_exit1_dr:   tap_state_d = tms_i ? st_update_dr : st_pause_dr;
			st_pause_dr:   tap_state_d = tms_i ? st_exit2_dr  : st_pause_dr;
			st_exit2_dr:   tap_state_d = tms_i ? st_update_dr : st_shift_dr;
			st_update_dr:  tap_state_d = tms_i ? st_select_dr : st_idle;
			st_select_ir:  tap_state_d = tms_i ? st_reset     : st_capture_ir;
			st_capture_ir: tap_state_d = tms_i ? st_exit1_ir  : st_shift_ir;
			st_shift_ir:   tap_state_d = tms_i ? st_exit1_ir  : st_shift_ir;
			st_exit1_ir:   tap_state_d = tms_i ? st_update_ir : st_pause_ir;
			st_pause_ir:   tap_state_d = tms_i ? st_exit2_ir  : st_pause_ir;
			st_exit2_ir:   tap_state_d = tms_i ? st_update_ir : st_shift_ir;
			st_update_ir:  tap_state_d = tms_i ? st_select_dr : st_idle;
		endcase
	end

	assign test_logic_reset = (tap_state_q == st_reset);
	assign capture_dr_o = (tap_state_q == st_capture_dr);
	assign shift_dr_o = (tap_state_q == st_shift_dr);
	assign update_dr_o = (tap_state_q == st_update_dr);
	assign capture_ir = (tap_state_q == st_capture_ir);
	assign shift_ir = (tap_state_q == st_shift_ir);
	assign update_ir = (tap_state_q == st_update_ir);

	// The controller comes out of reset in Run-Test-Idle.
	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			tap_state_q <= st_idle;
		end else begin
			tap_state_q <= tap_state_d;
		end
	end

	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			ir_shift_q <= '0;
			ir_q <= ir_idcode;
		end else if (test_logic_reset) begin
			ir_shift_q <= '0;
			ir_q <= ir_idcode;
		end else begin
			if (capture_ir) begin
				ir_shift_q <= ir_capture;
			end else if (shift_ir) begin
				ir_shift_q <= {td_i, ir_shift_q[`DMI_IR_LEN-1:1]};
			end
			if (update_ir) begin
				ir_q <= ir_shift_q;
			end
		end
	end

	// Codes without a register of their own fall back to BYPASS.
	always_comb begin
		idcode_select = 1'b0;
		dtmcs_select_o = 1'b0;
		dmi_access_o = 1'b0;
		bypass_select = 1'b0;
		case (ir_q)
			ir_idcode: idcode_select = 1'b1;
			ir_dtmcs:  dtmcs_select_o = 1'b1;
			ir_dmi:    dmi_access_o = 1'b1;
			default:   bypass_select = 1'b1;
		endcase
	end

	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			bypass_q <= 1'b0;
			idcode_q <= `DMI_IDCODE;
			dtmcs_q <= '0;
		end else if (test_logic_reset) begin
			bypass_q <= 1'b0;
			idcode_q <= `DMI_IDCODE;
			dtmcs_q <= '0;
		end else if (capture_dr_o) begin
			if (bypass_select) begin
				bypass_q <= 1'b0;
			end
			if (idcode_select) begin
				idcode_q <= `DMI_IDCODE;
			end
			// idle 1, dmistat, abits and version 1
			if (dtmcs_select_o) begin
				dtmcs_q <= {17'd0, 3'd1, dmi_error_i, 6'(`DMI_ABITS), 4'd1};
			end
		end else if (shift_dr_o) begin
			if (bypass_select) begin
				bypass_q <= td_i;
			end
			if (idcode_select) begin
				idcode_q <= {td_i, idcode_q[31:1]};
			end
			if (dtmcs_select_o) begin
				dtmcs_q <= {td_i, dtmcs_q[31:1]};
			end
		end
	end

	// The dmireset bit acts once, in the Update-DR cycle of a DTMCS scan.
	assign dmi_reset_o = update_dr_o & dtmcs_select_o & dtmcs_q[16];

	always_comb begin
		if (shift_ir) begin
			tdo_mux = ir_shift_q[0];
		end else if (idcode_select) begin
			tdo_mux = idcode_q[0];
		end else if (dtmcs_select_o) begin
			tdo_mux = dtmcs_q[0];
		end else if (dmi_access_o) begin
			tdo_mux = dmi_tdo_i;
		end else begin
			tdo_mux = bypass_q;
		end
	end

	// TDO is launched on the falling edge so the host samples it on the next rise.
	always_ff @(negedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			td_o <= 1'b0;
			tdo_oe_o <= 1'b0;
		end else begin
			td_o <= tdo_mux;
			tdo_oe_o <= shift_ir | shift_dr_o;
		end
	end

	a_state_known: assert property (@(posedge tck_i) disable iff (!trst_ni)
		!$isunknown(tap_state_q))
		else $error("TAP state is unknown");

endmodule

//--- source/dmi_jtag_dr.sv
`timescale 1ns/10ps

module dmi_jtag_dr import dmi_pkg::*; (
	input  logic       tck_i,
	input  logic       trst_ni,
	input  logic       td_i,
	input  logic       dmi_access_i,
	input  logic       capture_dr_i,
	input  logic       shift_dr_i,
	input  logic       update_dr_i,
	input  logic       dmi_reset_i,
	input  dmi_resp_t  resp_i,
	input  logic       resp_valid_i,
	output logic       dmi_tdo_o,
	output logic [1:0] dmi_error_o,
	output dmi_req_t   req_o,
	output logic       req_valid_o
);

	dmi_req_t  dr_q;
	dmi_req_t  dr_d;
	dmi_req_t  req_q;
	logic      req_valid_q;
	dmi_data_t data_q;
	dmi_op_e   status_q;
	dmi_op_e   status_d;
	logic      pending_q;
	logic      issue;

	// A request leaves only while the sticky status is clear.
	assign issue = update_dr_i && dmi_access_i && (status_q == op_success) &&
		(dr_q.op == op_read || dr_q.op == op_write);

	// The address field keeps what was shifted in by the previous scan.
	always_comb begin
		dr_d = dr_q;
		if (dmi_access_i && capture_dr_i) begin
			dr_d.data = data_q;
			dr_d.op = pending_q ? op_busy : status_q;
		end else if (dmi_access_i && shift_dr_i) begin
			dr_d = {td_i, dr_q[$bits(dmi_req_t)-1:1]};
		end
	end

	always_comb begin
		status_d = status_q;
		if (dmi_access_i && capture_dr_i && pending_q) begin
			status_d = op_busy;
		end else if (resp_valid_i && resp_i.op == op_failed && status_q != op_busy) begin
			status_d = op_failed;
		end
		if (dmi_reset_i) begin
			status_d = op_success;
		end
	end

	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			dr_q <= '0;
			data_q <= '0;
			status_q <= op_success;
			pending_q <= 1'b0;
			req_valid_q <= 1'b0;
		end else begin
			dr_q <= dr_d;
			status_q <= status_d;
			req_valid_q <= issue;
			if (issue) begin
				pending_q <= 1'b1;
			end else if (resp_valid_i) begin
				pending_q <= 1'b0;
			end
			// Late responses to a busy scan are still kept for the next capture.
			if (resp_valid_i) begin
				data_q <= resp_i.data;
			end
		end
	end

	always_ff @(posedge tck_i) begin
		if (issue) begin
			req_q <= dr_q;
		end
	end

	assign req_o = req_q;
	assign req_valid_o = req_valid_q;
	assign dmi_tdo_o = dr_q[0];
	assign dmi_error_o = status_q;

	a_resp_while_pending: assert property (@(posedge tck_i) disable iff (!trst_ni)
		resp_valid_i |-> pending_q)
		else $error("DMI response arrived with no request pending");

endmodule

//--- source/dmi_reg_file.sv
`timescale 1ns/10ps
`include "dmi_defs.svh"

module dmi_reg_file import dmi_pkg::*; (
	input  logic      tck_i,
	input  logic      trst_ni,
	input  dmi_req_t  req_i,
	input  logic      req_valid_i,
	output dmi_resp_t resp_o,
	output logic      resp_valid_o
);

	localparam int idx_w = $clog2(`DMI_NREGS);
	localparam int cnt_w = $clog2(`DMI_RESP_LAT + 1);

	dmi_data_t        regs_q [`DMI_NREGS];
	dmi_resp_t        resp_d;
	dmi_resp_t        resp_q;
	logic [cnt_w-1:0] cnt_q;
	logic [idx_w-1:0] idx;
	logic             in_range;

	assign idx = req_i.addr[idx_w-1:0];
	assign in_range = req_i.addr < dmi_addr_t'(`DMI_NREGS);

	// Out-of-range accesses answer failed with zero data.
	always_comb begin
		resp_d.data = '0;
		resp_d.op = op_failed;
		if (in_range) begin
			resp_d.op = op_success;
			if (req_i.op == op_write) begin
				resp_d.data = req_i.data;
			end else begin
				resp_d.data = regs_q[idx];
			end
		end
	end

	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			for (int i = 0; i < `DMI_NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (req_valid_i && in_range && req_i.op == op_write) begin
			regs_q[idx] <= req_i.data;
		end
	end

	// A new request restarts the countdown.
	always_ff @(posedge tck_i or negedge trst_ni) begin
		if (!trst_ni) begin
			cnt_q <= '0;
		end else if (req_valid_i) begin
			cnt_q <= cnt_w'(`DMI_RESP_LAT);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge tck_i) begin
		if (req_valid_i) begin
			resp_q <= resp_d;
		end
	end

	assign resp_o = resp_q;
	assign resp_valid_o = (cnt_q == cnt_w'(1));

endmodule

//--- source/dmi_jtag_top.sv
`timescale 1ns/10ps

module dmi_jtag_top import dmi_pkg::*; (
	input  logic tck_i,
	input  logic trst_ni,
	input  logic tms_i,
	input  logic td_i,
	output logic td_o,
	output logic tdo_oe_o
);

	logic       dmi_access;
	logic       capture_dr;
	logic       shift_dr;
	logic       update_dr;
	logic       dmi_reset;
	logic       dmi_tdo;
	logic [1:0] dmi_error;
	dmi_req_t   req;
	logic       req_valid;
	dmi_resp_t  resp;
	logic       resp_valid;

	// DTMCS selection reaches the DR only through the dmireset pulse.
	dmi_jtag_tap i_tap (
		.tck_i          (tck_i),
		.trst_ni        (trst_ni),
		.tms_i          (tms_i),
		.td_i           (td_i),
		.dmi_error_i    (dmi_error),
		.dmi_tdo_i      (dmi_tdo),
		.td_o           (td_o),
		.tdo_oe_o       (tdo_oe_o),
		.capture_dr_o   (capture_dr),
		.shift_dr_o     (shift_dr),
		.update_dr_o    (update_dr),
		.dmi_access_o   (dmi_access),
		.dtmcs_select_o (),
		.dmi_reset_o    (dmi_reset)
	);

	dmi_jtag_dr i_dr (
		.tck_i        (tck_i),
		.trst_ni      (trst_ni),
		.td_i         (td_i),
		.dmi_access_i (dmi_access),
		.capture_dr_i (capture_dr),
		.shift_dr_i   (shift_dr),
		.update_dr_i  (update_dr),
		.dmi_reset_i  (dmi_reset),
		.resp_i       (resp),
		.resp_valid_i (resp_valid),
		.dmi_tdo_o    (dmi_tdo),
		.dmi_error_o  (dmi_error),
		.req_o        (req),
		.req_valid_o  (req_valid)
	);

	dmi_reg_file i_reg_file (
		.tck_i        (tck_i),
		.trst_ni      (trst_ni),
		.req_i        (req),
		.req_valid_i  (req_valid),
		.resp_o       (resp),
		.resp_valid_o (resp_valid)
	);

endmodule

//--- test/tb_checker.sv
`timescale 1ns/10ps
`include "dmi_defs.svh"

module tb_checker import dmi_pkg::*; (
	input  logic       tck_i,
	input  logic       trst_ni,
	input  logic       tms_i,
	input  logic       td_i,
	input  logic       td_o,
	input  logic       tdo_oe_o,
	input  logic [2:0] test_id_i,
	output int         errors_o
);

	tap_state_e  st;
	logic [4:0]  ir;
	logic [4:0]  ir_sh;
	logic        byp;
	logic [31:0] idc;
	logic [31:0] dtm;
	logic [40:0] dmi;
	dmi_data_t   regs [`DMI_NREGS];
	dmi_data_t   last_data;
	dmi_data_t   resp_data;
	logic [1:0]  resp_op;
	logic [1:0]  status;
	logic        pend;
	int          cnt;
	int          errors = 0;

	assign errors_o = errors;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "idcode";
			3'd2: return "bypass";
			3'd3: return "dmi_read_write";
			3'd4: return "dmi_failed";
			3'd5: return "dmi_busy";
			3'd6: return "dtmcs_fields";
			default: return "reset";
		endcase
	endfunction

	// IEEE 1149.1 state transitions.
	function automatic tap_state_e tap_next(input tap_state_e s, input logic tms);
		case (s)
			st_reset:      return tms ? st_reset : st_idle;
			st_idle:       return tms ? st_select_dr : st_idle;
			st_select_dr:  return tms ? st_select_ir : st_capture_dr;
			st_capture_dr: return tms ? st_exit1_dr : st_shift_dr;
			st_shift_dr:   return tms ? st_exit1_dr : st_shift_dr;
			st_exit1_dr:   return tms ? st_update_dr : st_pause_dr;
			st_pause_dr:   return tms ? st_exit2_dr : st_pause_dr;
			st_exit2_dr:   return tms ? st_update_dr : st_shift_dr;
			st_update_dr:  return tms ? st_select_dr : st_idle;
			st_select_ir:  return tms ? st_reset : st_capture_ir;
			st_capture_ir: return tms ? st_exit1_ir : st_shift_ir;
			st_shift_ir:   return tms ? st_exit1_ir : st_shift_ir;
			st_exit1_ir:   return tms ? st_update_ir : st_pause_ir;
			st_pause_ir:   return tms ? st_exit2_ir : st_pause_ir;
			st_exit2_ir:   return tms ? st_update_ir : st_shift_ir;
			default:       return tms ? st_select_dr : st_idle;
		endcase
	endfunction

	always @(posedge tck_i or negedge trst_ni) begin : model
		logic       exp_oe;
		logic       exp_td;
		logic       idc_sel;
		logic       dtm_sel;
		logic       dmi_sel;
		logic       issue_now;
		logic       resp_now;
		logic [1:0] status_n;
		logic [6:0] a;
		if (!trst_ni) begin
			st = st_idle;
			ir = 5'h01;
			ir_sh = '0;
			byp = 1'b0;
			idc = `DMI_IDCODE;
			dtm = '0;
			dmi = '0;
			for (int i = 0; i < `DMI_NREGS; i++) begin
				regs[i] = '0;
			end
			last_data = '0;
			resp_data = '0;
			resp_op = '0;
			status = '0;
			pend = 1'b0;
			cnt = 0;
		end else begin
			idc_sel = (ir == 5'h01);
			dtm_sel = (ir == 5'h10);
			dmi_sel = (ir == 5'h11);

			// TDO was launched on the last falling edge from the current state.
			exp_oe = (st == st_shift_ir) || (st == st_shift_dr);
			if (tdo_oe_o !== exp_oe) begin
				errors++;
				$display("mismatch %s: expected tdo_oe_o %b, actual %b",
					test_name(test_id_i), exp_oe, tdo_oe_o);
			end
			if (exp_oe) begin
				if (st == st_shift_ir) exp_td = ir_sh[0];
				else if (idc_sel) exp_td = idc[0];
				else if (dtm_sel) exp_td = dtm[0];
				else if (dmi_sel) exp_td = dmi[0];
				else exp_td = byp;
				if (td_o !== exp_td) begin
					errors++;
					$display("mismatch %s: expected td_o %b, actual %b",
						test_name(test_id_i), exp_td, td_o);
				end
			end

			issue_now = (st == st_update_dr) && dmi_sel && (status == 2'd0) &&
				(dmi[1:0] == 2'd1 || dmi[1:0] == 2'd2);
			resp_now = 1'b0;
			if (pend) begin
				cnt--;
				resp_now = (cnt == 0);
			end

			status_n = status;
			if (st == st_capture_dr && dmi_sel && pend) begin
				status_n = 2'd3;
			end else if (resp_now && resp_op == 2'd2 && status != 2'd3) begin
				status_n = 2'd2;
			end
			if (st == st_update_dr && dtm_sel && dtm[16]) begin
				status_n = 2'd0;
			end

			if (st == st_reset) begin
				byp = 1'b0;
				idc = `DMI_IDCODE;
				dtm = '0;
				ir = 5'h01;
				ir_sh = '0;
			end else if (st == st_capture_dr) begin
				if (!idc_sel && !dtm_sel && !dmi_sel) byp = 1'b0;
				if (idc_sel) idc = `DMI_IDCODE;
				// Version, abits, dmistat and idle fill the low fifteen bits of dtmcs.
				if (dtm_sel) begin
					dtm = '0;
					dtm[3:0] = 4'd1;
					dtm[9:4] = 6'(`DMI_ABITS);
					dtm[11:10] = status;
					dtm[14:12] = 3'd1;
				end
				if (dmi_sel) begin
					dmi[33:2] = last_data;
					dmi[1:0] = pend ? 2'd3 : status;
				end
			end else if (st == st_shift_dr) begin
				if (!idc_sel && !dtm_sel && !dmi_sel) byp = td_i;
				if (idc_sel) idc = {td_i, idc[31:1]};
				if (dtm_sel) dtm = {td_i, dtm[31:1]};
				if (dmi_sel) dmi = {td_i, dmi[40:1]};
			end else if (st == st_capture_ir) begin
				ir_sh = 5'b00101;
			end else if (st == st_shift_ir) begin
				ir_sh = {td_i, ir_sh[4:1]};
			end else if (st == st_update_ir) begin
				ir = ir_sh;
			end

			if (resp_now) begin
				last_data = resp_data;
				pend = 1'b0;
			end
			if (issue_now) begin
				a = dmi[40:34];
				if (a < 7'(`DMI_NREGS)) begin
					resp_op = 2'd0;
					if (dmi[1:0] == 2'd2) begin
						regs[a[3:0]] = dmi[33:2];
						resp_data = dmi[33:2];
					end else begin
						resp_data = regs[a[3:0]];
					end
				end else begin
					resp_op = 2'd2;
					resp_data = '0;
				end
				pend = 1'b1;
				cnt = `DMI_RESP_LAT + 1;
			end

			status = status_n;
			st = tap_next(st, tms_i);
		end
	end

endmodule

//--- test/tb_top.sv
`timescale 1ns/10ps
`include "dmi_defs.svh"

module tb_top import dmi_pkg::*;;

	logic        tck_i;
	logic        trst_ni;
	logic        tms_i;
	logic        td_i;
	logic        td_o;
	logic        tdo_oe_o;
	logic [2:0]  test_id;
	int          chk_errors;
	int          timeouts;
	int unsigned lcg_state;

	dmi_jtag_top dut0 (
		.tck_i    (tck_i),
		.trst_ni  (trst_ni),
		.tms_i    (tms_i),
		.td_i     (td_i),
		.td_o     (td_o),
		.tdo_oe_o (tdo_oe_o)
	);

	tb_checker check0 (
		.tck_i     (tck_i),
		.trst_ni   (trst_ni),
		.tms_i     (tms_i),
		.td_i      (td_i),
		.td_o      (td_o),
		.tdo_oe_o  (tdo_oe_o),
		.test_id_i (test_id),
		.errors_o  (chk_errors)
	);

	initial begin
		tck_i = 1'b0;
		forever #4 tck_i = ~tck_i;
	end

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic fail_on_timeout(input string what);
		timeouts++;
		$display("Timeout: %s did not finish in time.", what);
		$display("Errors: %0d mismatches, %0d timeouts", chk_errors, timeouts);
		$display("Simulation failed");
		$finish;
	endtask

	// TMS and TDI set here take effect at the next rising edge.
	task automatic clock_tms(input logic tms, input logic tdi);
		@(posedge tck_i);
		tms_i <= tms;
		td_i <= tdi;
	endtask

	task automatic run_idle(input int n);
		repeat (n) clock_tms(1'b0, 1'b0);
	endtask

	task automatic wait_shift_done();
		int n;
		n = 0;
		while (tdo_oe_o && n < 16) begin
			clock_tms(1'b0, 1'b0);
			n++;
		end
		if (tdo_oe_o) fail_on_timeout("waiting for the TDO enable to drop");
	endtask

	task automatic scan_dr(input logic [63:0] bits, input int n);
		clock_tms(1'b1, 1'b0);
		clock_tms(1'b0, 1'b0);
		clock_tms(1'b0, 1'b0);
		for (int i = 0; i < n; i++) begin
			clock_tms(i == n - 1, bits[i]);
		end
		clock_tms(1'b1, 1'b0);
		clock_tms(1'b0, 1'b0);
		wait_shift_done();
	endtask

	task automatic load_ir(input logic [4:0] code);
		clock_tms(1'b1, 1'b0);
		clock_tms(1'b1, 1'b0);
		clock_tms(1'b0, 1'b0);
		clock_tms(1'b0, 1'b0);
		for (int i = 0; i < 5; i++) begin
			clock_tms(i == 4, code[i]);
		end
		clock_tms(1'b1, 1'b0);
		clock_tms(1'b0, 1'b0);
		wait_shift_done();
	endtask

	task automatic dmi_access(input dmi_addr_t addr, input dmi_data_t data, input dmi_op_e op);
		scan_dr({23'd0, addr, data, op}, 41);
	endtask

	task automatic tap_reset();
		repeat (5) clock_tms(1'b1, 1'b0);
		clock_tms(1'b0, 1'b0);
	endtask

	initial begin
		#2000000;
		$display("Timeout: the test sequence did not finish in time.");
		$display("Errors: %0d mismatches, %0d timeouts", chk_errors, timeouts);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [15:0] r;
		dmi_addr_t   addr;
		lcg_state = 54;
		timeouts = 0;
		test_id = 3'd0;
		tms_i = 1'b0;
		td_i = 1'b0;
		trst_ni = 1'b0;
		repeat (2) @(posedge tck_i);
		trst_ni <= 1'b1;
		wait_shift_done();

		// A non-IDCODE instruction is loaded first so that the TMS reset has to restore IDCODE.
		test_id = 3'd1;
		scan_dr({32'd0, rand16(), rand16()}, 32);
		load_ir(5'h10);
		tap_reset();
		scan_dr({32'd0, rand16(), rand16()}, 32);

		test_id = 3'd2;
		repeat (6) begin
			r = rand16();
			if (r[4:0] == 5'h01 || r[4:0] == 5'h10 || r[4:0] == 5'h11) r[2] = ~r[2];
			load_ir(r[4:0]);
			scan_dr({rand16(), rand16(), rand16(), rand16()}, 8 + int'(rand16() % 24));
		end

		test_id = 3'd3;
		load_ir(5'h11);
		repeat (16) begin
			r = rand16();
			dmi_access({3'd0, r[3:0]}, {rand16(), rand16()}, r[8] ? op_write : op_read);
			run_idle(`DMI_RESP_LAT + int'(rand16() % 3));
		end
		dmi_access('0, '0, op_nop);

		test_id = 3'd4;
		dmi_access(dmi_addr_t'(16 + int'(rand16() % 112)), '0, op_read);
		run_idle(`DMI_RESP_LAT + 2);
		load_ir(5'h10);
		scan_dr(64'd0, 32);
		load_ir(5'h11);
		r = rand16();
		addr = {3'd0, r[3:0]};
		dmi_access(addr, {rand16(), rand16()}, op_write);
		run_idle(`DMI_RESP_LAT + 2);
		dmi_access(addr, '0, op_read);
		run_idle(`DMI_RESP_LAT + 2);
		load_ir(5'h10);
		scan_dr(64'h1_0000, 32);
		scan_dr(64'd0, 32);
		load_ir(5'h11);
		dmi_access(addr, '0, op_read);
		run_idle(`DMI_RESP_LAT + 2);
		dmi_access('0, '0, op_nop);

		test_id = 3'd5;
		r = rand16();
		dmi_access({3'd0, r[3:0]}, '0, op_read);
		r = rand16();
		dmi_access({3'd0, r[3:0]}, '0, op_read);
		run_idle(`DMI_RESP_LAT + 2);
		load_ir(5'h10);
		scan_dr(64'd0, 32);
		scan_dr(64'h1_0000, 32);
		load_ir(5'h11);
		dmi_access('0, '0, op_nop);

		test_id = 3'd6;
		load_ir(5'h10);
		repeat (3) scan_dr({32'd0, rand16(), rand16()}, 32);
		run_idle(4);

		$display("Errors: %0d mismatches, %0d timeouts", chk_errors, timeouts);
		if (chk_errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+source
source/dmi_pkg.sv
source/dmi_jtag_tap.sv
source/dmi_jtag_dr.sv
source/dmi_reg_file.sv
source/dmi_jtag_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }
